// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_dcache
FILELIST  = filelist.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: dcache_assert.sv
// Protocol assertions for the data cache, bound to the top level.
// Watches the bus strobe and the CPU acknowledge against open bus transfers.

`timescale 1ns/100ps

`include "dcache_cfg.svh"

module dcache_assert (
  input logic clk_i,
  input logic rst_ni,
  input logic biu_stb_o,
  input logic biu_stb_ack_i,
  input logic biu_burst_o,
  input logic biu_ack_i,
  input logic biu_err_i,
  input logic mem_ack_o,
  input logic stall_o
);

  int   fail_cnt = 0;  // Read by the testbench at the end
  logic open_q;
  int   beats_q;
  logic open_now, last_beat;

  assign open_now  = open_q || (biu_stb_o && biu_stb_ack_i);
  assign last_beat = !biu_burst_o || (beats_q == `DCACHE_BURST - 1);

  // --------------------------------------------------
  // Open transfer tracking
  // --------------------------------------------------
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      open_q  <= 1'b0;
      beats_q <= 0;
    end else if (!open_now) begin
      beats_q <= 0;
    end else if (biu_err_i) begin
      open_q  <= 1'b0;  // Error closes the transfer
      beats_q <= 0;
    end else if (biu_ack_i) begin
      beats_q <= beats_q + 1;
      open_q  <= !last_beat;
    end else begin
      open_q <= 1'b1;
    end
  end

  stb_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    biu_stb_o && !biu_stb_ack_i |=> biu_stb_o)
    else begin
      $error("biu_stb_o dropped before its acknowledge");
      fail_cnt++;
    end

  ack_outside_xfer: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_ack_o |-> !biu_stb_o && !open_q)
    else begin
      $error("mem_ack_o during an open bus transfer");
      fail_cnt++;
    end

  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> !stall_o && !mem_ack_o)
    else begin
      $error("stall_o or mem_ack_o high in reset");
      fail_cnt++;
    end

endmodule

bind dcache_core dcache_assert u_assert (.*);

// File: dcache_biu.sv
// Bus sequencer of the data cache.
// Runs a line burst or a single-word write per command and pulses done_o
// with the assembled line, or with err_o when the bus reports an error.

`timescale 1ns/100ps

module dcache_biu import dcache_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  biu_cmd_e cmd_i,
  input  addr_t    adr_i,
  input  word_t    d_i,
  output logic     done_o,
  output logic     err_o,
  output line_t    line_o,
  // Bus
  output logic     biu_stb_o,
  input  logic     biu_stb_ack_i,
  output logic     biu_burst_o,
  output addr_t    biu_adri_o,
  output logic     biu_we_o,
  output word_t    biu_d_o,
  input  word_t    biu_q_i,
  input  logic     biu_ack_i,
  input  logic     biu_err_i
);

  logic  stb_q, xfer_q, burst_q, we_q, done_q, err_q;
  offs_t cnt_q;
  addr_t adr_q;
  word_t d_q;
  line_t line_q;
  logic  beat_en, last_beat;

  assign beat_en   = xfer_q || (stb_q && biu_stb_ack_i);  // Beats may follow the ack at once
  assign last_beat = !burst_q || (&cnt_q);

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      stb_q   <= 1'b0;
      xfer_q  <= 1'b0;
      burst_q <= 1'b0;
      we_q    <= 1'b0;
      done_q  <= 1'b0;
      err_q   <= 1'b0;
      cnt_q   <= '0;
    end else begin
      done_q <= 1'b0;
      err_q  <= 1'b0;
      if (cmd_i != BIU_NONE) begin
        stb_q   <= 1'b1;
        burst_q <= (cmd_i == BIU_READ_LINE);
        we_q    <= (cmd_i == BIU_WRITE_WORD);
        cnt_q   <= '0;
      end else if (stb_q && biu_stb_ack_i) begin
        stb_q  <= 1'b0;
        xfer_q <= 1'b1;
      end
      if (beat_en && biu_err_i) begin    // Error ends the transfer
        xfer_q <= 1'b0;
        done_q <= 1'b1;
        err_q  <= 1'b1;
      end else if (beat_en && biu_ack_i) begin
        cnt_q <= cnt_q + 1'b1;
        if (last_beat) begin
          xfer_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (cmd_i == BIU_READ_LINE) adr_q <= {adr_i[31:OFFS_BITS+2], {(OFFS_BITS + 2){1'b0}}};
    else if (cmd_i == BIU_WRITE_WORD) adr_q <= {adr_i[31:2], 2'b00};
    if (cmd_i != BIU_NONE) d_q <= d_i;
    if (beat_en && biu_ack_i && burst_q) line_q[cnt_q] <= biu_q_i;
  end

  assign done_o      = done_q;
  assign err_o       = err_q;
  assign line_o      = line_q;
  assign biu_stb_o   = stb_q;
  assign biu_burst_o = burst_q;
  assign biu_adri_o  = adr_q;
  assign biu_we_o    = we_q;
  assign biu_d_o     = d_q;

endmodule

// File: dcache_cfg.svh
// Geometry of the set-associative data cache.
// Included by the package and by the testbench. Edit these values to resize
// the cache. Ways, sets and burst length must be powers of two.

`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

`define DCACHE_XLEN       32       // Data and address width
`define DCACHE_WAYS       2        // Ways per set, up to 128
`define DCACHE_SETS       16       // Sets per way
`define DCACHE_BURST      4        // Words per line
`define DCACHE_LFSR_SEED  7'h2b    // Nonzero, never all ones

`endif

// File: dcache_core.sv
// Top level of the data cache.
// Setup stage registers the CPU request, the tag stage compares and
// answers. A read hit acknowledges two cycles after it is accepted.

`timescale 1ns/100ps

module dcache_core import dcache_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  // CPU side
  input  logic  mem_req_i,
  input  logic  mem_we_i,
  input  addr_t mem_adr_i,
  input  word_t mem_d_i,
  output word_t mem_q_o,
  output logic  mem_ack_o,
  output logic  mem_err_o,
  output logic  stall_o,
  // Bus side
  output logic  biu_stb_o,
  input  logic  biu_stb_ack_i,
  output logic  biu_burst_o,
  output addr_t biu_adri_o,
  output logic  biu_we_o,
  output word_t biu_d_o,
  input  word_t biu_q_i,
  input  logic  biu_ack_i,
  input  logic  biu_err_i
);

  logic     setup_vld_q, setup_we_q, tag_vld_q, tag_we_q;
  addr_t    setup_adr_q, tag_adr_q;
  word_t    setup_d_q, tag_d_q;
  idx_t     rd_idx, tag_idx;
  tag_t     tag_tag;
  offs_t    tag_offs;
  logic     hit, filling, fill_we, wr_we, cmd_done, cmd_err;
  way_vec_t ways_hit, fill_way;
  word_t    hit_word;
  line_t    biu_line;
  biu_cmd_e biu_cmd;

  // --------------------------------------------------
  // Setup and tag stage registers
  // --------------------------------------------------
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      setup_vld_q <= 1'b0;
      tag_vld_q   <= 1'b0;
    end else if (!stall_o) begin
      setup_vld_q <= mem_req_i;
      tag_vld_q   <= setup_vld_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_o) begin
      setup_we_q  <= mem_we_i;
      setup_adr_q <= mem_adr_i;
      setup_d_q   <= mem_d_i;
      tag_we_q    <= setup_we_q;
      tag_adr_q   <= setup_adr_q;
      tag_d_q     <= setup_d_q;
    end
  end

  assign rd_idx   = setup_adr_q[2 + OFFS_BITS +: IDX_BITS];
  assign tag_idx  = tag_adr_q[2 + OFFS_BITS +: IDX_BITS];
  assign tag_offs = tag_adr_q[2 +: OFFS_BITS];
  assign tag_tag  = tag_adr_q[31 -: TAG_BITS];

  dcache_lfsr_way u_lfsr_way (
    .clk_i, .rst_ni, .filling_i (filling), .fill_way_o (fill_way)
  );

  dcache_memory u_memory (
    .clk_i, .rst_ni, .stall_i (stall_o),
    .rd_idx_i   (rd_idx),  .tag_i       (tag_tag),  .offs_i     (tag_offs),
    .hit_o      (hit),     .ways_hit_o  (ways_hit), .word_o     (hit_word),
    .fill_we_i  (fill_we), .fill_way_i  (fill_way), .fill_idx_i (tag_idx),
    .fill_tag_i (tag_tag), .fill_line_i (biu_line),
    .wr_we_i    (wr_we),   .wr_idx_i    (tag_idx),  .wr_offs_i  (tag_offs),
    .wr_ways_i  (ways_hit), .wr_data_i  (tag_d_q)
  );

  dcache_ctrl u_ctrl (
    .clk_i, .rst_ni,
    .req_i      (tag_vld_q), .we_i   (tag_we_q),  .adr_i      (tag_adr_q), .d_i (tag_d_q),
    .hit_i      (hit),       .ways_hit_i (ways_hit), .word_i  (hit_word),
    .stall_o,   .ack_o (mem_ack_o), .err_o (mem_err_o), .q_o  (mem_q_o),
    .filling_o  (filling),   .fill_we_o  (fill_we), .wr_we_o  (wr_we),
    .biu_cmd_o  (biu_cmd),   .cmd_done_i (cmd_done), .cmd_err_i (cmd_err),
    .line_i     (biu_line)
  );

  dcache_biu u_biu (
    .clk_i, .rst_ni,
    .cmd_i  (biu_cmd),  .adr_i (tag_adr_q), .d_i    (tag_d_q),
    .done_o (cmd_done), .err_o (cmd_err),   .line_o (biu_line),
    .biu_stb_o, .biu_stb_ack_i, .biu_burst_o, .biu_adri_o, .biu_we_o,
    .biu_d_o,   .biu_q_i,       .biu_ack_i,   .biu_err_i
  );

endmodule

// File: dcache_ctrl.sv
// Hit-stage controller of the data cache.
// Answers read hits at once, stalls for misses and writes, and hands line
// fills and write-through words to the bus unit.

`timescale 1ns/100ps

module dcache_ctrl import dcache_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  // Tag-stage request
  input  logic     req_i,
  input  logic     we_i,
  input  addr_t    adr_i,
  input  word_t    d_i,
  // From the memory
  input  logic     hit_i,
  input  way_vec_t ways_hit_i,
  input  word_t    word_i,
  // CPU answer
  output logic     stall_o,
  output logic     ack_o,
  output logic     err_o,
  output word_t    q_o,
  // Fill and write hit
  output logic     filling_o,
  output logic     fill_we_o,
  output logic     wr_we_o,
  // Bus unit
  output biu_cmd_e biu_cmd_o,
  input  logic     cmd_done_i,
  input  logic     cmd_err_i,
  input  line_t    line_i
);

  typedef enum logic [1:0] {ST_LOOKUP, ST_WAIT_FILL, ST_WAIT_WRITE} state_e;

  state_e state_q, state_d;
  offs_t  offs;
  logic   rd_miss;

  assign offs    = adr_i[2 +: OFFS_BITS];
  assign rd_miss = req_i && !we_i && !hit_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_LOOKUP: begin
        if (req_i && we_i) state_d = ST_WAIT_WRITE;
        else if (rd_miss) state_d = ST_WAIT_FILL;
      end
      default: if (cmd_done_i) state_d = ST_LOOKUP;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) state_q <= ST_LOOKUP;
    else state_q <= state_d;
  end

  // --------------------------------------------------
  // Bus commands, one-cycle pulses
  // --------------------------------------------------
  always_comb begin
    biu_cmd_o = BIU_NONE;
    if (state_q == ST_LOOKUP) begin
      if (req_i && we_i) biu_cmd_o = BIU_WRITE_WORD;
      else if (rd_miss) biu_cmd_o = BIU_READ_LINE;
    end
  end

  // --------------------------------------------------
  // CPU side
  // --------------------------------------------------
  always_comb begin
    if (state_q == ST_LOOKUP) begin
      stall_o = req_i && (we_i || !hit_i);
      ack_o   = req_i && !we_i && hit_i;
    end else begin
      stall_o = !cmd_done_i;           // Drops with the final ack
      ack_o   = cmd_done_i;
    end
  end

  assign err_o = (state_q != ST_LOOKUP) && cmd_done_i && cmd_err_i;

  always_comb begin
    case (state_q)
      ST_WAIT_FILL:  q_o = line_i[offs];  // Requested word from the new line
      ST_WAIT_WRITE: q_o = d_i;           // Echo of the stored word
      default:       q_o = word_i;
    endcase
  end

  // Cache updates only after an error-free bus transfer
  assign filling_o = (state_q == ST_WAIT_FILL);
  assign fill_we_o = filling_o && cmd_done_i && !cmd_err_i;
  assign wr_we_o   = (state_q == ST_WAIT_WRITE) && cmd_done_i && !cmd_err_i && |ways_hit_i;

endmodule

// File: dcache_lfsr_way.sv
// Random way selection for line replacement.
// The LFSR freezes during a fill so the chosen way stays stable.

`timescale 1ns/100ps

`include "dcache_cfg.svh"

module dcache_lfsr_way import dcache_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     filling_i,
  output way_vec_t fill_way_o
);

  localparam int WAYS     = `DCACHE_WAYS;
  localparam int WAY_BITS = (WAYS > 1) ? $clog2(WAYS) : 1;

  logic [6:0] lfsr_q;  // Covers up to 128 ways

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) lfsr_q <= `DCACHE_LFSR_SEED;
    else if (!filling_i) lfsr_q <= {lfsr_q[5:0], lfsr_q[6] ~^ lfsr_q[5]};
  end

  if (WAYS == 1) begin : g_direct
    assign fill_way_o = way_vec_t'(1);  // Direct mapped
  end else begin : g_assoc
    assign fill_way_o = way_vec_t'(1) << lfsr_q[WAY_BITS-1:0];
  end

endmodule

// File: dcache_memory.sv
// Tag, valid and data storage of all ways with hit detection.
// The set index is registered when the pipeline is not stalled; the arrays
// are read from that register, so fills and write hits show up in the
// very next lookup.

`timescale 1ns/100ps

`include "dcache_cfg.svh"

module dcache_memory import dcache_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     stall_i,
  // Lookup
  input  idx_t     rd_idx_i,
  input  tag_t     tag_i,
  input  offs_t    offs_i,
  output logic     hit_o,
  output way_vec_t ways_hit_o,
  output word_t    word_o,
  // Line fill
  input  logic     fill_we_i,
  input  way_vec_t fill_way_i,
  input  idx_t     fill_idx_i,
  input  tag_t     fill_tag_i,
  input  line_t    fill_line_i,
  // Write hit
  input  logic     wr_we_i,
  input  idx_t     wr_idx_i,
  input  offs_t    wr_offs_i,
  input  way_vec_t wr_ways_i,
  input  word_t    wr_data_i
);

  localparam int WAYS = `DCACHE_WAYS;
  localparam int SETS = `DCACHE_SETS;

  tag_t                       tag_mem [WAYS][SETS];
  line_t                      dat_mem [WAYS][SETS];
  logic [WAYS-1:0][SETS-1:0]  valid_q;
  idx_t                       idx_q;   // Lookup register

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) idx_q <= '0;
    else if (!stall_i) idx_q <= rd_idx_i;
  end

  // --------------------------------------------------
  // Valid bits
  // --------------------------------------------------
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (fill_we_i) begin
      for (int w = 0; w < WAYS; w++) begin
        if (fill_way_i[w]) valid_q[w][fill_idx_i] <= 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Tag and data arrays
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < WAYS; w++) begin
      if (fill_we_i && fill_way_i[w]) begin
        tag_mem[w][fill_idx_i] <= fill_tag_i;
        dat_mem[w][fill_idx_i] <= fill_line_i;   // Whole line at once
      end else if (wr_we_i && wr_ways_i[w]) begin
        dat_mem[w][wr_idx_i][wr_offs_i] <= wr_data_i;
      end
    end
  end

  // Compare all ways, OR together the hit word
  always_comb begin
    word_o = '0;
    for (int w = 0; w < WAYS; w++) begin
      ways_hit_o[w] = valid_q[w][idx_q] && (tag_mem[w][idx_q] == tag_i);
      if (ways_hit_o[w]) word_o = word_o | dat_mem[w][idx_q][offs_i];
    end
  end

  assign hit_o = |ways_hit_o;

endmodule

// File: dcache_pkg.sv
// Shared widths and types of the data cache.
// Compiled first. RTL files pull it in with a wildcard import.

`include "dcache_cfg.svh"

package dcache_pkg;

  // Address split  | tag | idx | offs | byte |
  localparam int OFFS_BITS = $clog2(`DCACHE_BURST);
  localparam int IDX_BITS  = $clog2(`DCACHE_SETS);
  localparam int TAG_BITS  = `DCACHE_XLEN - IDX_BITS - OFFS_BITS - 2;

  typedef logic [`DCACHE_XLEN-1:0]                    word_t;
  typedef logic [`DCACHE_XLEN-1:0]                    addr_t;
  typedef logic [TAG_BITS-1:0]                        tag_t;
  typedef logic [IDX_BITS-1:0]                        idx_t;
  typedef logic [OFFS_BITS-1:0]                       offs_t;
  typedef logic [`DCACHE_BURST-1:0][`DCACHE_XLEN-1:0] line_t;
  typedef logic [`DCACHE_WAYS-1:0]                    way_vec_t;  // One-hot

  typedef enum logic [1:0] {BIU_NONE, BIU_READ_LINE, BIU_WRITE_WORD} biu_cmd_e;

endpackage

// File: dcache_stim.txt
# op addr data err expect (hex). op 0 miss read, 1 hit read, 2 write,
# 3 any read, 4 back-to-back hit read, 5 end of test with addr = min bursts
0 00000104 00000000 0 a5a50104
5 00000001 00000000 0 00000000
1 00000100 00000000 0 a5a50100
1 0000010c 00000000 0 a5a5010c
5 00000000 00000000 0 00000000
2 00000108 12345678 0 12345678
1 00000108 00000000 0 12345678
5 00000000 00000000 0 00000000
3 00000030 00000000 0 a5a50030
3 00001030 00000000 0 a5a51030
3 00002030 00000000 0 a5a52030
3 00000030 00000000 0 a5a50030
3 00001030 00000000 0 a5a51030
3 00002030 00000000 0 a5a52030
5 00000004 00000000 0 00000000
0 00000340 00000000 1 00000000
0 00000340 00000000 0 a5a50340
5 00000002 00000000 0 00000000
4 00000100 00000000 0 a5a50100
4 00000104 00000000 0 a5a50104
4 00000108 00000000 0 12345678
4 0000010c 00000000 0 a5a5010c
5 00000000 00000000 0 00000000

// File: filelist.f
+incdir+.
dcache_pkg.sv
dcache_lfsr_way.sv
dcache_memory.sv
dcache_ctrl.sv
dcache_biu.sv
dcache_core.sv
dcache_assert.sv
tb_dcache.sv

// File: tb_dcache.sv
// Testbench of the data cache.
// Replays dcache_stim.txt against the DUT with a bus memory model that
// inserts random stalls, and checks data, latency and bus traffic.

`timescale 1ns/100ps

`include "dcache_cfg.svh"

module tb_dcache;

  localparam logic [31:0] MEM_PATTERN = 32'hA5A5_0000;  // Unwritten word = addr ^ pattern
  localparam int          CYC_PER_OP  = 200;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        mem_req_i, mem_we_i, mem_ack_o, mem_err_o, stall_o;
  logic [31:0] mem_adr_i, mem_d_i, mem_q_o;
  logic        biu_stb_o, biu_stb_ack_i, biu_burst_o, biu_we_o, biu_ack_i, biu_err_i;
  logic [31:0] biu_adri_o, biu_d_o, biu_q_i;

  int          seed = 32'h1504_17b7;
  int          n_ops = 0;
  int          errors = 0, test_errs = 0, tests = 0, passed = 0;
  int          bursts = 0, xfers = 0, beats = 0;
  logic        err_req = 1'b0;      // Next read burst fails on its first beat
  logic [31:0] line_adr = '0;
  logic [31:0] store [logic [31:0]];
  logic [31:0] ops[$], adrs[$], dats[$], errs[$], exps[$];

  always #2 clk_i = ~clk_i;

  dcache_core u_dcache_core (.*);

  function automatic logic [31:0] mem_read(logic [31:0] a);
    return store.exists(a) ? store[a] : (a ^ MEM_PATTERN);
  endfunction

  function automatic int rand_gap();
    return $unsigned($random(seed)) % 4;
  endfunction

  task automatic report_value(string name, logic [31:0] got, logic [31:0] exp);
    $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    errors++;
    test_errs++;
  endtask

  task automatic report_text(string msg);
    $display("Failure at %0t: %s", $time, msg);
    errors++;
    test_errs++;
  endtask

  // --------------------------------------------------
  // Bus memory model
  // --------------------------------------------------
  always begin
    logic [31:0] adr;
    logic        is_burst;
    int          nbeat;
    @(negedge clk_i);
    if (biu_stb_o) begin
      adr      = biu_adri_o;
      is_burst = biu_burst_o;
      xfers++;
      if (is_burst) begin
        bursts++;
        if (adr != line_adr) report_value("biu_adri_o", adr, line_adr);
        if (biu_we_o !== 1'b0) report_value("biu_we_o", {31'h0, biu_we_o}, 32'h0);
      end else if (biu_we_o) begin
        store[adr] = biu_d_o;
      end
      repeat (rand_gap()) @(negedge clk_i);
      biu_stb_ack_i = 1'b1;
      @(negedge clk_i);
      biu_stb_ack_i = 1'b0;
      nbeat = is_burst ? `DCACHE_BURST : 1;
      for (int i = 0; i < nbeat; i++) begin
        repeat (rand_gap()) @(negedge clk_i);
        if (is_burst && err_req && i == 0) begin
          biu_err_i = 1'b1;  // Error replaces the beat and ends it
          @(negedge clk_i);
          biu_err_i = 1'b0;
          break;
        end
        biu_ack_i = 1'b1;
        biu_q_i   = mem_read(adr + 4 * i);
        beats++;
        @(negedge clk_i);
        biu_ack_i = 1'b0;
      end
    end
  end

  // Issues one request and waits for its acknowledge
  task automatic run_single(int op, logic [31:0] adr, logic [31:0] dat,
                            logic err, logic [31:0] exp);
    int lat, x0, b0, n0;
    x0       = xfers;
    b0       = bursts;
    n0       = beats;
    line_adr = {adr[31:4], 4'h0};
    err_req  = err;
    @(negedge clk_i);
    mem_req_i = 1'b1;
    mem_we_i  = (op == 2);
    mem_adr_i = adr;
    mem_d_i   = dat;
    @(negedge clk_i);
    mem_req_i = 1'b0;
    lat = 1;
    while (!mem_ack_o) begin
      @(negedge clk_i);
      lat++;
    end
    if (stall_o !== 1'b0) report_value("stall_o", {31'h0, stall_o}, 32'h0);
    if (err) begin
      if (mem_err_o !== 1'b1) report_value("mem_err_o", {31'h0, mem_err_o}, 32'h1);
    end else begin
      if (mem_err_o !== 1'b0) report_value("mem_err_o", {31'h0, mem_err_o}, 32'h0);
      if (op != 2 && mem_q_o !== exp) report_value("mem_q_o", mem_q_o, exp);
    end
    if (op == 1 && lat != 2) report_text($sformatf("hit latency %0d cycles, not 2", lat));
    if (op == 1 && xfers != x0) report_text("bus transfer on a read hit");
    if (op == 0 && bursts != b0 + 1) report_text("read miss did not start exactly one burst");
    if (op == 0 && !err && beats != n0 + `DCACHE_BURST) report_text("burst beat count wrong");
    if (op == 2 && mem_read(adr) !== dat) report_value("store", mem_read(adr), dat);
  endtask

  // Back-to-back hits that must acknowledge once per cycle
  task automatic run_back_to_back(int first, int last);
    int cnt, x0;
    cnt = last - first;
    x0  = xfers;
    for (int k = 0; k < cnt + 2; k++) begin
      @(negedge clk_i);
      if (stall_o) report_text("stall_o high during back-to-back hits");
      if (k >= 2) begin
        if (!mem_ack_o) report_text($sformatf("no acknowledge for hit %0d", k - 2));
        else if (mem_q_o !== exps[first + k - 2]) report_value("mem_q_o", mem_q_o,
                                                              exps[first + k - 2]);
      end
      mem_req_i = (k < cnt);
      mem_we_i  = 1'b0;
      if (k < cnt) mem_adr_i = adrs[first + k];
    end
    if (xfers != x0) report_text("bus transfer during back-to-back hits");
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    int          fd, r, i, j, b_test;
    string       line;
    logic [31:0] f_op, f_adr, f_dat, f_err, f_exp;
    rst_ni = 1'b0;
    {mem_req_i, mem_we_i, biu_stb_ack_i, biu_ack_i, biu_err_i} = '0;
    {mem_adr_i, mem_d_i, biu_q_i} = '0;
    fd = $fopen("dcache_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file");
      $display("RESULT: FAIL");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        r = $fgets(line, fd);
        if (r > 2 && line[0] != "#") begin
          r = $sscanf(line, "%h %h %h %h %h", f_op, f_adr, f_dat, f_err, f_exp);
          if (r == 5) begin
            ops.push_back(f_op);
            adrs.push_back(f_adr);
            dats.push_back(f_dat);
            errs.push_back(f_err);
            exps.push_back(f_exp);
          end
        end
      end
      $fclose(fd);
      n_ops = ops.size();
      repeat (10) @(posedge clk_i);
      @(negedge clk_i);
      rst_ni = 1'b1;
      b_test = 0;
      i = 0;
      while (i < n_ops) begin
        if (ops[i] == 4) begin
          j = i;
          while (j < n_ops && ops[j] == 4) j++;
          run_back_to_back(i, j);
          i = j;
        end else if (ops[i] == 5) begin   // End of test with the minimum burst count in addr
          tests++;
          if (bursts - b_test < int'(adrs[i])) report_text("too few refill bursts");
          if (test_errs == 0) passed++;
          $display("Test %0d %s, %0d bursts", tests, (test_errs == 0) ? "passed" : "failed",
                   bursts - b_test);
          test_errs = 0;
          b_test    = bursts;
          i++;
        end else begin
          run_single(int'(ops[i]), adrs[i], dats[i], errs[i][0], exps[i]);
          i++;
        end
      end
      repeat (4) @(negedge clk_i);
      errors += u_dcache_core.u_assert.fail_cnt;
      $display("%0d tests, %0d passed, %0d errors", tests, passed, errors);
      if (errors == 0 && tests > 0) $display("RESULT: PASS");
      else $display("RESULT: FAIL");
      $finish;
    end
  end

  // Watchdog
  initial begin
    wait (n_ops > 0);
    repeat (n_ops * CYC_PER_OP) @(posedge clk_i);
    $display("Timeout, the stimulus did not finish in %0d cycles", n_ops * CYC_PER_OP);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule
